/* Makefile */
# Verilator build and run of the UMI memory endpoint testbench

SIM  := obj_dir/Vtb_umi_mem_top
SRCS := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) filelist.f
	verilator --binary --timing --assert -j 0 --top-module tb_umi_mem_top -f filelist.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+logic
logic/umi_pkg.sv
logic/umi_decode.sv
logic/umi_endpoint.sv
logic/umi_regmem.sv
logic/umi_mem_top.sv
verif/tb_umi_mem_top.sv

/* logic/umi_consts.svh */
`ifndef UMI_CONSTS_SVH
`define UMI_CONSTS_SVH

//############################################################
// Link widths
//############################################################
`define UMI_CW 32                 // Command word
`define UMI_AW 32                 // Address
`define UMI_DW 64                 // Data beat

// Local memory geometry
`define UMI_MEM_DEPTH 64          // Words
`define UMI_MEM_AW 6              // Word address bits, dstaddr[8:3]

//############################################################
// Opcodes
//############################################################
// Requests are odd
`define UMI_REQ_READ 5'd1
`define UMI_REQ_WRITE 5'd3
`define UMI_REQ_POSTED 5'd5
`define UMI_REQ_ATOMIC 5'd9
// Responses are even
`define UMI_RESP_READ 5'd2
`define UMI_RESP_WRITE 5'd4

// Atomic kinds, carried in the len field
`define UMI_ATYPE_ADD 8'd0
`define UMI_ATYPE_SWAP 8'd1

// Error field codes
`define UMI_ERR_NONE 2'd0
`define UMI_ERR_DEV 2'd3

`endif

/* logic/umi_decode.sv */
`default_nettype none
`timescale 1ns/10ps

`include "umi_consts.svh"

module umi_decode
   import umi_pkg::*;
   (
   input  umi_cmd_u   cmd,       // Request command word
   output umi_class_e cls,       // Request class
   output umi_amo_e   amo,       // Atomic kind, only meaningful for CLS_ATOMIC
   output logic [2:0] size       // Access size code
   );

   //############################################################
   // Opcode classification
   //############################################################
   always_comb
   begin
      size = cmd.std.size;       // Same bits in both views
      amo  = AMO_ADD;            // Default for non-atomics
      case (cmd.std.opcode)
         `UMI_REQ_READ:
            cls = (cmd.std.len != 8'd0) ? CLS_ERROR : CLS_READ;
         `UMI_REQ_WRITE:
            cls = (cmd.std.len != 8'd0) ? CLS_ERROR : CLS_WRITE;
         `UMI_REQ_POSTED:
            cls = (cmd.std.len != 8'd0) ? CLS_ERROR : CLS_POSTED;
         `UMI_REQ_ATOMIC:
         begin
            // Len slot is the atype here
            case (cmd.amo.atype)
               `UMI_ATYPE_ADD:
               begin
                  cls = CLS_ATOMIC;
                  amo = AMO_ADD;
               end
               `UMI_ATYPE_SWAP:
               begin
                  cls = CLS_ATOMIC;
                  amo = AMO_SWAP;
               end
               default:
                  cls = CLS_ERROR;   // Other atomics not built
            endcase
         end
         default:
            cls = CLS_ERROR;         // Responses, link and unknown opcodes
      endcase
   end

   // A known command word must never leave the class undefined
   always_comb
   begin
      if (!$isunknown(cmd))
         assert (!$isunknown(cls))
         else $error("umi_decode: class is X for command %h", cmd);
   end

endmodule

`default_nettype wire

/* logic/umi_endpoint.sv */
`default_nettype none
`timescale 1ns/10ps

`include "umi_consts.svh"

module umi_endpoint
   import umi_pkg::*;
   (
   input  logic                   clk,
   input  logic                   nreset,
   // Device port, request side
   input  logic                   req_valid,
   input  umi_cmd_u               req_cmd,
   input  logic [`UMI_AW-1:0]     req_dstaddr,
   input  logic [`UMI_AW-1:0]     req_srcaddr,
   input  logic [`UMI_DW-1:0]     req_data,
   output logic                   req_ready,
   // Device port, response side
   output logic                   resp_valid,
   output umi_cmd_u               resp_cmd,
   output logic [`UMI_AW-1:0]     resp_dstaddr,
   output logic [`UMI_AW-1:0]     resp_srcaddr,
   output logic [`UMI_DW-1:0]     resp_data,
   input  logic                   resp_ready,
   // From decoder
   input  umi_class_e             cls,
   input  umi_amo_e               amo,
   input  logic [2:0]             size,
   // To memory
   output logic [`UMI_MEM_AW-1:0] mem_addr,
   output logic                   mem_write,
   output logic                   mem_read,
   output logic                   mem_atomic,
   output umi_amo_e               mem_amo,
   output logic [2:0]             mem_size,
   output logic [`UMI_DW-1:0]     mem_wrdata,
   // From memory
   input  logic [`UMI_DW-1:0]     mem_rddata
   );

   logic                xfer;          // Request handshake this cycle
   logic                needs_resp;    // Everything but posted writes answers
   logic                load;          // Capture a new response
   logic                rd_sel;        // Response carries memory data
   logic                resp_fresh;    // First cycle of a response
   logic [`UMI_DW-1:0]  data_hold;     // Read data kept across stalls
   umi_cmd_u            cmd_next;

   //############################################################
   // Request side
   //############################################################
   // Stall only while a held response is refused
   assign req_ready  = ~resp_valid | resp_ready;
   assign xfer       = req_valid & req_ready;
   assign needs_resp = (cls != CLS_POSTED);
   assign load       = xfer & needs_resp;

   // Memory strobes, one cycle wide
   assign mem_write  = xfer & ((cls == CLS_WRITE) | (cls == CLS_POSTED));
   assign mem_read   = xfer & (cls == CLS_READ);
   assign mem_atomic = xfer & (cls == CLS_ATOMIC);
   assign mem_addr   = req_dstaddr[`UMI_MEM_AW+2:3];   // Word index
   assign mem_amo    = amo;
   assign mem_size   = size;
   assign mem_wrdata = req_data;

   //############################################################
   // Response build
   //############################################################
   always_comb
   begin
      cmd_next = req_cmd;                             // Copy all std fields
      if ((cls == CLS_READ) || (cls == CLS_ATOMIC))
         cmd_next.std.opcode = `UMI_RESP_READ;
      else
         cmd_next.std.opcode = `UMI_RESP_WRITE;       // Writes and errors
      cmd_next.std.err = (cls == CLS_ERROR) ? `UMI_ERR_DEV : `UMI_ERR_NONE;
   end

   // Valid and data select
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         resp_valid <= 1'b0;
         resp_fresh <= 1'b0;
         rd_sel     <= 1'b0;
      end
      else
      begin
         if (load)
            resp_valid <= 1'b1;
         else if (resp_ready)
            resp_valid <= 1'b0;                       // Delivered, nothing new
         resp_fresh <= load;
         if (load)
            rd_sel <= (cls == CLS_READ) | (cls == CLS_ATOMIC);
      end
   end

   // Header fields, addresses swapped
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         resp_cmd     <= cmd_next;
         resp_dstaddr <= req_srcaddr;
         resp_srcaddr <= req_dstaddr;
      end
   end

   // Memory data is only valid in the first cycle
   always_ff @(posedge clk)
   begin
      if (resp_fresh)
         data_hold <= resp_data;
   end

   always_comb
   begin
      if (resp_fresh)
         resp_data = rd_sel ? mem_rddata : '0;
      else
         resp_data = data_hold;
   end

   //############################################################
   // Checks
   //############################################################
   // No response is withdrawn before the host takes it
   assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid)
      else $error("umi_endpoint: resp_valid dropped without transfer");

   // Held response does not change
   assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> $stable(resp_cmd) && $stable(resp_dstaddr)
                                    && $stable(resp_srcaddr) && $stable(resp_data))
      else $error("umi_endpoint: response fields changed while stalled");

endmodule

`default_nettype wire

/* logic/umi_mem_top.sv */
`default_nettype none
`timescale 1ns/10ps

`include "umi_consts.svh"

module umi_mem_top
   import umi_pkg::*;
   (
   input  logic               clk,
   input  logic               nreset,
   // Device port
   input  logic               req_valid,
   input  logic [`UMI_CW-1:0] req_cmd,
   input  logic [`UMI_AW-1:0] req_dstaddr,
   input  logic [`UMI_AW-1:0] req_srcaddr,
   input  logic [`UMI_DW-1:0] req_data,
   output logic               req_ready,
   output logic               resp_valid,
   output logic [`UMI_CW-1:0] resp_cmd,
   output logic [`UMI_AW-1:0] resp_dstaddr,
   output logic [`UMI_AW-1:0] resp_srcaddr,
   output logic [`UMI_DW-1:0] resp_data,
   input  logic               resp_ready
   );

   // Decoder outputs
   umi_class_e             cls;
   umi_amo_e               amo;
   logic [2:0]             size;
   // Memory port
   logic [`UMI_MEM_AW-1:0] mem_addr;
   logic                   mem_write;
   logic                   mem_read;
   logic                   mem_atomic;
   umi_amo_e               mem_amo;
   logic [2:0]             mem_size;
   logic [`UMI_DW-1:0]     mem_wrdata;
   logic [`UMI_DW-1:0]     mem_rddata;

   umi_decode decode_i (.cmd(req_cmd), .cls(cls), .amo(amo), .size(size));

   umi_endpoint endpoint_i (
      .clk(clk), .nreset(nreset),
      .req_valid(req_valid), .req_cmd(req_cmd), .req_dstaddr(req_dstaddr),
      .req_srcaddr(req_srcaddr), .req_data(req_data), .req_ready(req_ready),
      .resp_valid(resp_valid), .resp_cmd(resp_cmd), .resp_dstaddr(resp_dstaddr),
      .resp_srcaddr(resp_srcaddr), .resp_data(resp_data), .resp_ready(resp_ready),
      .cls(cls), .amo(amo), .size(size),
      .mem_addr(mem_addr), .mem_write(mem_write), .mem_read(mem_read),
      .mem_atomic(mem_atomic), .mem_amo(mem_amo), .mem_size(mem_size),
      .mem_wrdata(mem_wrdata), .mem_rddata(mem_rddata));

   umi_regmem regmem_i (
      .clk(clk), .nreset(nreset), .addr(mem_addr), .write(mem_write),
      .read(mem_read), .atomic(mem_atomic), .amo(mem_amo), .size(mem_size),
      .wrdata(mem_wrdata), .rddata(mem_rddata));

endmodule

`default_nettype wire

/* logic/umi_pkg.sv */
`default_nettype none

package umi_pkg;

   // Plain command layout, msb first
   typedef struct packed {
      logic [2:0] spare;      // [31:29]
      logic [1:0] err;        // [28:27]
      logic [1:0] user;       // [26:25]
      logic       ex;         // [24]
      logic       eof;        // [23]
      logic       eom;        // [22]
      logic [1:0] prot;       // [21:20]
      logic [3:0] qos;        // [19:16]
      logic [7:0] len;        // [15:8] beats minus one
      logic [2:0] size;       // [7:5] 2^size bytes
      logic [4:0] opcode;     // [4:0]
   } umi_std_t;

   // Atomic layout, len slot holds the operation
   typedef struct packed {
      logic [2:0] spare;
      logic [1:0] err;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] atype;      // Add, swap, ...
      logic [2:0] size;
      logic [4:0] opcode;
   } umi_amo_t;

   // One command word, two readings
   typedef union packed {
      umi_std_t std;
      umi_amo_t amo;
   } umi_cmd_u;

   // Request class after decode
   typedef enum logic [2:0] {CLS_READ, CLS_WRITE, CLS_POSTED, CLS_ATOMIC, CLS_ERROR} umi_class_e;

   // Supported atomics
   typedef enum logic {AMO_ADD, AMO_SWAP} umi_amo_e;

endpackage

`default_nettype wire

/* logic/umi_regmem.sv */
`default_nettype none
`timescale 1ns/10ps

`include "umi_consts.svh"

module umi_regmem
   import umi_pkg::*;
   (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic [`UMI_MEM_AW-1:0] addr,      // Word address
   input  logic                   write,     // Byte-sized write
   input  logic                   read,      // Plain read
   input  logic                   atomic,    // Read-modify-write
   input  umi_amo_e               amo,       // Add or swap
   input  logic [2:0]             size,      // 2^size bytes
   input  logic [`UMI_DW-1:0]     wrdata,
   output logic [`UMI_DW-1:0]     rddata     // Old word, one cycle later
   );

   logic [`UMI_DW-1:0] mem [0:`UMI_MEM_DEPTH-1];
   logic [`UMI_DW-1:0] old_word;
   logic [`UMI_DW-1:0] lane_mask;    // Bits touched by this access
   logic [`UMI_DW-1:0] sum_word;
   logic [`UMI_DW-1:0] new_word;

   assign old_word = mem[addr];

   //############################################################
   // Lane select and update value
   //############################################################
   always_comb
   begin
      case (size)
         3'd0:    lane_mask = 64'h0000_0000_0000_00ff;
         3'd1:    lane_mask = 64'h0000_0000_0000_ffff;
         3'd2:    lane_mask = 64'h0000_0000_ffff_ffff;
         default: lane_mask = '1;    // 8 bytes and anything wider
      endcase
   end

   // Low bits of the sum ignore upper carries, so masking wraps in lane
   assign sum_word = old_word + wrdata;

   always_comb
   begin
      if (atomic && (amo == AMO_ADD))
         new_word = (old_word & ~lane_mask) | (sum_word & lane_mask);
      else
         new_word = (old_word & ~lane_mask) | (wrdata & lane_mask); // Write or swap
   end

   // Array, cleared on reset
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < `UMI_MEM_DEPTH; i++)
            mem[i] <= '0;
      end
      else if (write || atomic)
         mem[addr] <= new_word;
   end

   // Old value for reads and atomics
   always_ff @(posedge clk)
   begin
      if (read || write || atomic)
         rddata <= old_word;
   end

   // Endpoint issues one access per cycle
   assert property (@(posedge clk) disable iff (!nreset)
      $onehot0({write, read, atomic}))
      else $error("umi_regmem: more than one strobe active");

endmodule

`default_nettype wire

/* verif/tb_umi_mem_top.sv */
`default_nettype none
`timescale 1ns/10ps

`include "umi_consts.svh"

module tb_umi_mem_top;

   localparam int TIMEOUT = 50;          // Cycles allowed per wait

   logic               clk;
   logic               nreset;
   logic               req_valid;
   logic [`UMI_CW-1:0] req_cmd;
   logic [`UMI_AW-1:0] req_dstaddr;
   logic [`UMI_AW-1:0] req_srcaddr;
   logic [`UMI_DW-1:0] req_data;
   logic               req_ready;
   logic               resp_valid;
   logic [`UMI_CW-1:0] resp_cmd;
   logic [`UMI_AW-1:0] resp_dstaddr;
   logic [`UMI_AW-1:0] resp_srcaddr;
   logic [`UMI_DW-1:0] resp_data;
   logic               resp_ready = 1'b1;

   integer             seed = 32'h6bd5_1bb5;     // Request stream
   integer             bp_seed = 32'h6bd5_1bb5;  // Back-pressure stream
   logic               stall_en = 1'b0;          // Random resp_ready when set
   int                 accept_cnt = 0;           // Request transfers so far
   logic [`UMI_DW-1:0] ref_mem [0:`UMI_MEM_DEPTH-1];
   logic [159:0]       exp_q [$];                // {cmd, dstaddr, srcaddr, data}

   umi_mem_top dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //############################################################
   // Helpers
   //############################################################
   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [63:0] want,
                              input logic [63:0] got);
      assert (got === want)
      else stop_run($sformatf("MISMATCH t=%0t %s expected %h got %h",
                              $time, name, want, got));
   endtask

   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   // Low 2^size bytes replaced by data or by a byte-wise sum
   function automatic logic [63:0] update_word(input logic [63:0] old,
                                               input logic [63:0] data,
                                               input logic [2:0]  size,
                                               input logic        add);
      logic [63:0] word;
      logic [8:0]  acc;
      word = old;
      acc  = '0;
      for (int b = 0; b < 8; b++)
      begin
         if (b < (1 << size))
         begin
            if (add)
            begin
               acc = {1'b0, old[b*8 +: 8]} + {1'b0, data[b*8 +: 8]} + {8'd0, acc[8]};
               word[b*8 +: 8] = acc[7:0];       // Carry out of the lane is lost
            end
            else
               word[b*8 +: 8] = data[b*8 +: 8];
         end
      end
      update_word = word;
   endfunction

   //############################################################
   // Reference model run on each request transfer
   //############################################################
   task automatic model_request();
      logic [4:0]  opc;
      logic [7:0]  len;
      logic [5:0]  idx;
      logic [63:0] old;
      logic [2:0]  size;
      logic [31:0] cmd;
      logic        is_err;
      logic        rd_data;
      opc     = req_cmd[4:0];
      len     = req_cmd[15:8];                   // Atype for atomics
      idx     = req_dstaddr[8:3];
      old     = ref_mem[idx];
      size    = req_cmd[7:5];
      is_err  = 1'b0;
      rd_data = 1'b0;
      case (opc)
         `UMI_REQ_READ:
         begin
            is_err  = (len != 8'd0);
            rd_data = 1'b1;
         end
         `UMI_REQ_WRITE, `UMI_REQ_POSTED:
         begin
            is_err = (len != 8'd0);
            if (!is_err)
               ref_mem[idx] = update_word(old, req_data, size, 1'b0);
         end
         `UMI_REQ_ATOMIC:
         begin
            rd_data = 1'b1;
            if (len == `UMI_ATYPE_ADD)
               ref_mem[idx] = update_word(old, req_data, size, 1'b1);
            else if (len == `UMI_ATYPE_SWAP)
               ref_mem[idx] = update_word(old, req_data, size, 1'b0);
            else
               is_err = 1'b1;
         end
         default:
            is_err = 1'b1;                      // Even or unused opcode
      endcase
      if (is_err)
         rd_data = 1'b0;
      if ((opc == `UMI_REQ_POSTED) && !is_err)
         return;                                // Posted writes stay silent
      cmd        = req_cmd;
      cmd[4:0]   = rd_data ? `UMI_RESP_READ : `UMI_RESP_WRITE;
      cmd[28:27] = is_err ? `UMI_ERR_DEV : `UMI_ERR_NONE;
      exp_q.push_back({cmd, req_srcaddr, req_dstaddr, rd_data ? old : 64'h0});
   endtask

   // Monitor checks responses before modeling new requests
   always @(posedge clk)
   begin
      logic [159:0] item;
      if (!nreset)
      begin
         for (int i = 0; i < `UMI_MEM_DEPTH; i++)
            ref_mem[i] = '0;
         exp_q.delete();
      end
      else
      begin
         // Valid one cycle after each answered transfer and until taken
         check_value("resp_valid", 64'(exp_q.size() != 0), 64'(resp_valid));
         if (resp_valid && resp_ready)
         begin
            item = exp_q.pop_front();
            check_value("resp_cmd", 64'(item[159:128]), 64'(resp_cmd));
            check_value("resp_dstaddr", 64'(item[127:96]), 64'(resp_dstaddr));
            check_value("resp_srcaddr", 64'(item[95:64]), 64'(resp_srcaddr));
            check_value("resp_data", item[63:0], resp_data);
         end
         if (req_valid && req_ready)
         begin
            accept_cnt = accept_cnt + 1;
            model_request();
         end
      end
   end

   // Stall only while a held response is refused
   assert property (@(posedge clk) disable iff (!nreset)
      req_ready == !(resp_valid && !resp_ready))
      else stop_run("req_ready does not follow response back-pressure");

   assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd)
         && $stable(resp_dstaddr) && $stable(resp_srcaddr) && $stable(resp_data))
      else stop_run("held response dropped or changed while stalled");

   always @(negedge clk)
   begin
      if (stall_en)
         resp_ready = ($random(bp_seed) % 4) != 0;
      else
         resp_ready = 1'b1;
   end

   //############################################################
   // Stimulus
   //############################################################
   // kind 0 read, 1 write, 2 posted, 3 add, 4 swap, else malformed
   task automatic send_op(input int kind, input logic [5:0] w);
      logic [31:0] r;
      logic [31:0] a;
      logic [4:0]  opc;
      logic [7:0]  len;
      logic [2:0]  size;
      int          start;
      int          waited;
      r    = rand32();
      a    = rand32();
      len  = 8'd0;
      size = (kind == 0) ? 3'd3 : {1'b0, r[15:14]};     // Reads take the whole word
      case (kind)
         0: opc = `UMI_REQ_READ;
         1: opc = `UMI_REQ_WRITE;
         2: opc = `UMI_REQ_POSTED;
         3: opc = `UMI_REQ_ATOMIC;                      // Atype add is zero
         4:
         begin
            opc = `UMI_REQ_ATOMIC;
            len = `UMI_ATYPE_SWAP;
         end
         default:
         begin
            case (r[1:0])
               2'd0: opc = {r[6:3], 1'b0};              // Response opcode
               2'd1: opc = {r[4:3], 3'b111};            // Unused odd opcode
               2'd2:
               begin
                  opc = r[2] ? `UMI_REQ_WRITE : `UMI_REQ_READ;
                  len = {r[13:7], 1'b1};                // Unsupported burst length
               end
               default:
               begin
                  opc = `UMI_REQ_ATOMIC;
                  len = 8'd2 + {1'b0, r[13:7]};         // Atype past swap
               end
            endcase
         end
      endcase
      start       = accept_cnt;
      req_valid   = 1'b1;
      req_cmd     = {a[31:16], len, size, opc};         // Random qos, prot, user...
      req_dstaddr = {a[15:0], r[31:25], w, r[6:4]};
      req_srcaddr = rand32();
      req_data    = {rand32(), rand32()};
      waited      = 0;
      while (accept_cnt == start)
      begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT)
            stop_run("timeout waiting for a request transfer");
      end
      req_valid = 1'b0;
   endtask

   initial
   begin
      logic [31:0] r;
      int          waited;
      nreset      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      repeat (5) @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      check_value("req_ready", 64'd1, 64'(req_ready));
      check_value("resp_valid", 64'd0, 64'(resp_valid));
      // Fresh memory reads zero
      repeat (4)
      begin
         r = rand32();
         send_op(0, r[5:0]);
      end
      // Writes and posted writes each read back
      repeat (40)
      begin
         r = rand32();
         send_op(r[8] ? 1 : 2, r[5:0]);
         send_op(0, r[5:0]);
      end
      repeat (30)
      begin
         r = rand32();
         send_op(r[8] ? 3 : 4, r[5:0]);
         send_op(0, r[5:0]);
      end
      // Malformed requests followed by a read of the same word
      repeat (24)
      begin
         r = rand32();
         send_op(5, r[5:0]);
         send_op(0, r[5:0]);
      end
      // Mixed traffic under back-pressure on a few words
      stall_en = 1'b1;
      repeat (200)
      begin
         r = rand32();
         send_op(r[15:8] % 6, {3'b000, r[2:0]});
      end
      stall_en = 1'b0;
      waited   = 0;
      while (exp_q.size() != 0)
      begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT)
            stop_run("timeout waiting for outstanding responses");
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire
